// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= videoBackEnd_tb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/cpuWatchdog.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pixel_defs.svh"

module cpuWatchdog
(
	input wire CLK_1MB,
	input wire rstN,
	input wire pixelPkg::cpuBus_t cpu,
	output logic sysResetN     // Low during the reset pulse
);

	localparam int CNT_W = $clog2(`WDOG_LIMIT + 1);
	localparam int PULSE_W = $clog2(`WDOG_PULSE + 1);

	typedef enum logic
	{
		WD_COUNT,   // Waiting for kicks
		WD_PULSE    // Driving system reset
	} wdState_t;

	wdState_t state;
	logic [CNT_W-1:0] idleCnt;
	logic [PULSE_W-1:0] pulseCnt;
	logic kick;

	// Only writes to the watchdog region count
	assign kick = cpu.strobe && cpu.write && (cpu.region == pixelPkg::REG_WATCHDOG);

	always_ff @(posedge CLK_1MB)
	begin
		if (!rstN)
		begin
			state <= WD_COUNT;
			idleCnt <= '0;
			pulseCnt <= '0;
		end
		else
		begin
			case (state)
				WD_COUNT:
				begin
					pulseCnt <= '0;
					if (kick)
						idleCnt <= '0;
					else if (idleCnt == CNT_W'(`WDOG_LIMIT - 1))
					begin
						idleCnt <= '0;       // Rearm for after the pulse
						state <= WD_PULSE;   // Limit reached, fire
					end
					else
						idleCnt <= idleCnt + 1'b1;
				end
				WD_PULSE:
				begin
					// Kicks ignored while reset is asserted
					if (pulseCnt == PULSE_W'(`WDOG_PULSE - 1))
						state <= WD_COUNT;
					pulseCnt <= pulseCnt + 1'b1;
				end
				default: state <= WD_COUNT;
			endcase
		end
	end

	assign sysResetN = (state != WD_PULSE);

endmodule

`default_nettype wire

// ==== design/fixPipeline.sv ====
`timescale 1ns/1ns
`default_nettype none

module fixPipeline
(
	input wire CLK_1MB,
	input wire rstN,
	input wire fixLoad,              // New byte strobe
	input wire [7:0] fixByte,        // Two fix pixels, low nibble first
	input wire [3:0] fixPal,
	output pixelPkg::fixPixel_t fixOut
);

	// Which nibble is on the output
	typedef enum logic [1:0]
	{
		FIX_IDLE,
		FIX_LOW,
		FIX_HIGH
	} fixHalf_t;

	fixHalf_t half;
	logic [7:0] byteReg;   // Latched pixel pair
	logic [3:0] palReg;    // Latched palette

	// Byte and palette latch
	always_ff @(posedge CLK_1MB)
	begin
		if (fixLoad)
		begin
			byteReg <= fixByte;
			palReg <= fixPal;
		end
	end

	// Half tracker
	always_ff @(posedge CLK_1MB)
	begin
		if (!rstN)
			half <= FIX_IDLE;
		else if (fixLoad)
			half <= FIX_LOW;   // A reload restarts at the low nibble
		else
		begin
			case (half)
				FIX_LOW:  half <= FIX_HIGH;
				FIX_HIGH: half <= FIX_IDLE;
				default:  half <= FIX_IDLE;
			endcase
		end
	end

	// Nibble select, transparent once both pixels are out
	always_comb
	begin
		fixOut.palette = palReg;
		case (half)
			FIX_LOW:  fixOut.color = byteReg[3:0];
			FIX_HIGH: fixOut.color = byteReg[7:4];
			default:  fixOut.color = 4'd0;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/paletteMixer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pixel_defs.svh"

module paletteMixer
(
	input wire CLK_1MB,
	input wire rstN,
	input wire blank,                           // Forces address 0
	input wire pixelPkg::cpuBus_t cpu,
	input wire pixelPkg::spritePixel_t sprOut,
	input wire pixelPkg::fixPixel_t fixOut,
	output logic [`PAL_ADDR_W-1:0] paletteAddr
);

	logic blankD;      // Blank aligned to the sprite read data
	logic cpuPal;
	logic fixOpaque;
	logic [`PAL_ADDR_W-1:0] videoAddr;
	logic [`PAL_ADDR_W-1:0] nextAddr;

	// Palette access by the CPU, read or write
	assign cpuPal = cpu.strobe && (cpu.region == pixelPkg::REG_PALETTE);

	assign fixOpaque = (fixOut.color != 4'd0);

	// Fix above sprites, fix palette zero extended
	assign videoAddr = fixOpaque ? {4'b0000, fixOut.palette, fixOut.color}
		: {sprOut.palette, sprOut.color};

	// CPU first, then blanking, then video
	always_comb
	begin
		if (cpuPal)
			nextAddr = cpu.addr;
		else if (blankD)
			nextAddr = '0;
		else
			nextAddr = videoAddr;
	end

	always_ff @(posedge CLK_1MB)
	begin
		if (!rstN)
			blankD <= 1'b0;
		else
			blankD <= blank;   // Line buffer output lags by one cycle
	end

	// Palette address register
	always_ff @(posedge CLK_1MB)
	begin
		if (!rstN)
			paletteAddr <= '0;
		else
			paletteAddr <= nextAddr;
	end

endmodule

`default_nettype wire

// ==== design/pixelPkg.sv ====
`default_nettype none

`include "pixel_defs.svh"

package pixelPkg;

	// Sprite pixel as stored in the line buffers
	typedef struct packed
	{
		logic [7:0] palette;   // Sprite palette number
		logic [3:0] color;     // 0 is transparent
	} spritePixel_t;

	// Fix pixel, one nibble of a fix byte
	typedef struct packed
	{
		logic [3:0] palette;   // Fix palette number
		logic [3:0] color;     // 0 lets the sprite through
	} fixPixel_t;

	// Sprite fetcher write side
	typedef struct packed
	{
		logic loadX;                    // Load write counter
		logic [`LB_ADDR_W-1:0] xPos;    // Start X of the run
		logic we;                       // Write strobe
		spritePixel_t pixel;
	} spriteWrite_t;

	// Decoded CPU target
	typedef enum logic [1:0]
	{
		REG_NONE     = `REG_CODE_NONE,
		REG_PALETTE  = `REG_CODE_PALETTE,
		REG_WATCHDOG = `REG_CODE_WATCHDOG
	} busRegion_t;

	// One CPU cycle
	typedef struct packed
	{
		logic strobe;                   // Single cycle access
		logic write;                    // Level, high for write
		busRegion_t region;
		logic [`PAL_ADDR_W-1:0] addr;   // Word address
	} cpuBus_t;

endpackage

`default_nettype wire

// ==== design/spriteLineBuffers.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pixel_defs.svh"

module spriteLineBuffers
(
	input wire CLK_1MB,
	input wire rstN,
	input wire bufFlip,                          // Swaps buffer roles every line
	input wire pixelPkg::spriteWrite_t sprWr,
	input wire readStart,                        // Restart display at X 0
	input wire blank,
	output pixelPkg::spritePixel_t sprOut
);

	// Two line buffers, index 0 is A and index 1 is B
	pixelPkg::spritePixel_t lineBuf [2][`LB_DEPTH];

	logic [`LB_ADDR_W-1:0] wrCnt;   // Render side X counter
	logic [`LB_ADDR_W-1:0] rdCnt;   // Display side X counter
	logic [`LB_ADDR_W-1:0] wrAddr;
	logic [`LB_ADDR_W-1:0] rdAddr;
	logic wrBank;
	logic rdBank;
	logic wrHit;
	logic rdEn;

	// bufFlip 0 renders into A and shows B
	assign wrBank = bufFlip;
	assign rdBank = ~bufFlip;

	// Same cycle loadX wins over the counter
	assign wrAddr = sprWr.loadX ? sprWr.xPos : wrCnt;

	// Transparent pixels only move the counter
	assign wrHit = sprWr.we && (sprWr.pixel.color != 4'd0);

	// readStart in a visible cycle reads X 0 directly
	assign rdAddr = readStart ? '0 : rdCnt;
	assign rdEn = ~blank;

	// Write counter
	always_ff @(posedge CLK_1MB)
	begin
		if (!rstN)
			wrCnt <= '0;
		else if (sprWr.we)
			wrCnt <= wrAddr + 1'b1;   // Step after each pixel, opaque or not
		else if (sprWr.loadX)
			wrCnt <= sprWr.xPos;
	end

	// Read counter
	always_ff @(posedge CLK_1MB)
	begin
		if (!rstN)
			rdCnt <= '0;
		else if (rdEn)
			rdCnt <= rdAddr + 1'b1;
		else if (readStart)
			rdCnt <= '0;
	end

	// Buffer storage, render write and display clear hit opposite banks
	always_ff @(posedge CLK_1MB)
	begin
		if (!rstN)
		begin
			// Both lines start empty
			for (int b = 0; b < 2; b++)
			begin
				for (int i = 0; i < `LB_DEPTH; i++)
					lineBuf[b][i] <= '0;
			end
		end
		else
		begin
			if (wrHit)
				lineBuf[wrBank][wrAddr] <= sprWr.pixel;
			if (rdEn)
				lineBuf[rdBank][rdAddr] <= '0;   // Clear behind the beam
		end
	end

	// Display output, one cycle after the read
	always_ff @(posedge CLK_1MB)
	begin
		if (!rstN)
			sprOut <= '0;
		else if (rdEn)
			sprOut <= lineBuf[rdBank][rdAddr];
		else
			sprOut <= '0;   // Nothing shown in blanking
	end

endmodule

`default_nettype wire

// ==== design/videoBackEnd.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pixel_defs.svh"

module videoBackEnd
(
	input wire CLK_1MB,
	input wire rstN,
	input wire bufFlip,                          // Line buffer swap level
	input wire readStart,                        // Start of displayed line
	input wire blank,
	input wire pixelPkg::spriteWrite_t sprWr,
	input wire fixLoad,
	input wire [7:0] fixByte,
	input wire [3:0] fixPal,
	input wire pixelPkg::cpuBus_t cpu,
	output logic [`PAL_ADDR_W-1:0] paletteAddr,
	output logic sysResetN
);

	pixelPkg::spritePixel_t sprOut;   // Displayed sprite pixel
	pixelPkg::fixPixel_t fixOut;      // Current fix pixel

	// Sprite side
	spriteLineBuffers spriteLineBuffers_i
	(
		.CLK_1MB   (CLK_1MB),
		.rstN      (rstN),
		.bufFlip   (bufFlip),
		.sprWr     (sprWr),
		.readStart (readStart),
		.blank     (blank),
		.sprOut    (sprOut)
	);

	// Fix layer
	fixPipeline fixPipeline_i
	(
		.CLK_1MB (CLK_1MB),
		.rstN    (rstN),
		.fixLoad (fixLoad),
		.fixByte (fixByte),
		.fixPal  (fixPal),
		.fixOut  (fixOut)
	);

	// Palette address priority
	paletteMixer paletteMixer_i
	(
		.CLK_1MB     (CLK_1MB),
		.rstN        (rstN),
		.blank       (blank),
		.cpu         (cpu),
		.sprOut      (sprOut),
		.fixOut      (fixOut),
		.paletteAddr (paletteAddr)
	);

	cpuWatchdog cpuWatchdog_i
	(
		.CLK_1MB   (CLK_1MB),
		.rstN      (rstN),
		.cpu       (cpu),
		.sysResetN (sysResetN)
	);

endmodule

`default_nettype wire

// ==== dv/videoBackEnd_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pixel_defs.svh"

module videoBackEnd_asserts
(
	input wire CLK_1MB,
	input wire rstN,
	input wire blank,
	input wire pixelPkg::cpuBus_t cpu,
	input wire [`PAL_ADDR_W-1:0] paletteAddr,
	input wire sysResetN
);

	logic cpuPal;
	assign cpuPal = cpu.strobe && (cpu.region == pixelPkg::REG_PALETTE);

	// Blank reaches the address two edges later unless the CPU cuts in
	blankZero: assert property (@(posedge CLK_1MB)
		(rstN && blank) ##1 (rstN && !cpuPal) |=> (paletteAddr == '0))
		else $error("paletteAddr not zero after blank");

	// Fixed length system reset
	pulseLen: assert property (@(posedge CLK_1MB) disable iff (!rstN)
		$fell(sysResetN) |-> !sysResetN [*`WDOG_PULSE] ##1 sysResetN)
		else $error("sysResetN pulse length wrong");

	cpuOverride: assert property (@(posedge CLK_1MB) disable iff (!rstN)
		cpuPal |=> (paletteAddr == $past(cpu.addr)))
		else $error("CPU palette address not taken");

endmodule

bind videoBackEnd videoBackEnd_asserts videoBackEnd_asserts_i (.*);

`default_nettype wire

// ==== dv/videoBackEnd_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pixel_defs.svh"

module videoBackEnd_tb;

	logic CLK_1MB;
	logic rstN;
	logic bufFlip;
	logic readStart;
	logic blank;
	pixelPkg::spriteWrite_t sprWr;
	logic fixLoad;
	logic [7:0] fixByte;
	logic [3:0] fixPal;
	pixelPkg::cpuBus_t cpu;
	logic [`PAL_ADDR_W-1:0] paletteAddr;
	logic sysResetN;

	int seed = 92827;
	int errCount = 0;
	bit checkEn = 0;
	bit fixPhase = 0;   // Alternates fix loads

	// Reference model state
	logic [11:0] mBuf [2][256];
	logic [7:0] mWr;
	logic [7:0] mRd;
	logic [11:0] mSpr;           // Sprite pixel after the read register
	logic [7:0] mFixByte;
	logic [3:0] mFixPal;
	int mHalf;                   // 0 idle, 1 low nibble, 2 high nibble
	logic mBlankD;
	logic [11:0] expPal;
	int wdCnt;
	int pulseCnt;
	bit wdPulse;

	videoBackEnd videoBackEnd_i
	(
		.CLK_1MB     (CLK_1MB),
		.rstN        (rstN),
		.bufFlip     (bufFlip),
		.readStart   (readStart),
		.blank       (blank),
		.sprWr       (sprWr),
		.fixLoad     (fixLoad),
		.fixByte     (fixByte),
		.fixPal      (fixPal),
		.cpu         (cpu),
		.paletteAddr (paletteAddr),
		.sysResetN   (sysResetN)
	);

	initial
	begin
		CLK_1MB = 0;
		forever #10 CLK_1MB = ~CLK_1MB;
	end

	task automatic checkEq(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
		begin
			errCount++;
			$display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
			$display("=== FAIL ===");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// Model step, sees the inputs sampled at this edge
	always @(posedge CLK_1MB)
	begin
		logic [3:0] fc;
		logic [7:0] ra;
		logic [7:0] wa;
		if (!rstN)
		begin
			foreach (mBuf[b, i])
				mBuf[b][i] = '0;
			mWr = 0;
			mRd = 0;
			mSpr = 0;
			mHalf = 0;
			mBlankD = 0;
			expPal = 0;
			wdCnt = 0;
			pulseCnt = 0;
			wdPulse = 0;
			checkEn = 1;
		end
		else
		begin
			// Mixer from pre-edge pipeline state
			fc = (mHalf == 1) ? mFixByte[3:0] : (mHalf == 2) ? mFixByte[7:4] : 4'd0;
			if (cpu.strobe && cpu.region == pixelPkg::REG_PALETTE)
				expPal = cpu.addr;
			else if (mBlankD)
				expPal = 0;
			else if (fc != 0)
				expPal = {4'd0, mFixPal, fc};
			else
				expPal = mSpr;
			mBlankD = blank;
			// Display side, bufFlip 0 shows B
			if (!blank)
			begin
				ra = readStart ? 8'd0 : mRd;
				mSpr = mBuf[!bufFlip][ra];
				mBuf[!bufFlip][ra] = 0;
				mRd = ra + 8'd1;
			end
			else
			begin
				mSpr = 0;
				if (readStart)
					mRd = 0;
			end
			// Render side skips transparent pixels
			wa = sprWr.loadX ? sprWr.xPos : mWr;
			if (sprWr.we && sprWr.pixel.color != 0)
				mBuf[bufFlip][wa] = sprWr.pixel;
			if (sprWr.we)
				mWr = wa + 8'd1;
			else if (sprWr.loadX)
				mWr = sprWr.xPos;
			// Fix halves
			if (fixLoad)
			begin
				mFixByte = fixByte;
				mFixPal = fixPal;
				mHalf = 1;
			end
			else
				mHalf = (mHalf == 1) ? 2 : 0;
			// Watchdog
			if (!wdPulse)
			begin
				pulseCnt = 0;
				if (cpu.strobe && cpu.write && cpu.region == pixelPkg::REG_WATCHDOG)
					wdCnt = 0;
				else if (wdCnt == `WDOG_LIMIT - 1)
				begin
					wdCnt = 0;
					wdPulse = 1;
				end
				else
					wdCnt++;
			end
			else
			begin
				if (pulseCnt == `WDOG_PULSE - 1)
					wdPulse = 0;
				pulseCnt++;
			end
		end
	end

	// Outputs are settled at the falling edge
	always @(negedge CLK_1MB)
	begin
		if (checkEn)
		begin
			checkEq("paletteAddr", 32'(expPal), 32'(paletteAddr));
			checkEq("sysResetN", 32'(!wdPulse), 32'(sysResetN));
		end
	end

	// One clock of stimulus, cpuMode 0 off, 1 random, 2 kick, 3 watchdog read
	task automatic driveCycle(input bit rs, input bit blk, input bit fixOn, input int cpuMode);
		int r;
		@(posedge CLK_1MB);
		readStart <= rs;
		blank <= blk;
		r = $random(seed) & 15;
		sprWr.loadX <= (r == 0);
		sprWr.xPos <= 8'($random(seed));
		sprWr.we <= (r > 5);
		sprWr.pixel.palette <= 8'($random(seed));
		sprWr.pixel.color <= (r == 7) ? 4'd0 : 4'($random(seed));   // Some transparent
		fixPhase = !fixPhase;
		fixLoad <= fixOn && fixPhase;
		fixByte <= 8'($random(seed));
		fixPal <= 4'($random(seed));
		r = $random(seed) & 7;
		cpu.addr <= 12'($random(seed));
		cpu.strobe <= (cpuMode == 1) ? (r < 4) : (cpuMode > 1);
		cpu.write <= (cpuMode == 2) || (cpuMode == 1 && r[0]);
		if (cpuMode >= 2 || r == 2)
			cpu.region <= pixelPkg::REG_WATCHDOG;
		else if (r == 3)
			cpu.region <= pixelPkg::REG_NONE;
		else
			cpu.region <= pixelPkg::REG_PALETTE;
	endtask

	// Blanked render time, then a full displayed line
	task automatic runLine(input bit flip, input bit fixOn, input bit cpuOn);
		@(posedge CLK_1MB);
		bufFlip <= flip;
		blank <= 1'b1;   // No display read while the roles swap
		for (int i = 0; i < 40; i++)
			driveCycle(0, 1, fixOn, cpuOn ? 1 : 0);
		for (int i = 0; i < `LB_DEPTH; i++)
			driveCycle(i == 0, cpuOn && (i % 50 > 40), fixOn, cpuOn ? 1 : 0);
	endtask

	initial
	begin
		int n;
		rstN = 0;
		bufFlip = 0;
		readStart = 0;
		blank = 1;
		sprWr = '0;
		fixLoad = 0;
		fixByte = 0;
		fixPal = 0;
		cpu = '0;
		repeat (4) @(posedge CLK_1MB);
		rstN <= 1;

		// Ping-pong lines, transparency and clear on read
		for (int l = 0; l < 6; l++)
			runLine(l[0], 0, 0);
		// Fix layer over sprites
		for (int l = 0; l < 4; l++)
			runLine(l[0], 1, 0);
		// CPU palette access and blanking
		for (int l = 0; l < 3; l++)
			runLine(l[0], 1, 1);

		// Kick through any pulse so the idle count starts fresh
		n = 0;
		@(negedge CLK_1MB);
		while ((!sysResetN || n < 2) && n < `WDOG_PULSE + 4)
		begin
			driveCycle(0, 1, 0, 2);
			@(negedge CLK_1MB);
			n++;
		end
		if (!sysResetN)
		begin
			$display("=== FAIL ===");
			$fatal(1, "watchdog reset pulse did not end");
		end
		// Regular kicks hold the watchdog off
		for (int i = 0; i < 6 * `WDOG_LIMIT; i++)
		begin
			driveCycle(0, 1, 0, (i % (`WDOG_LIMIT / 2) == 0) ? 2 : 0);
			@(negedge CLK_1MB);
			checkEq("sysResetN", 1, 32'(sysResetN));
		end
		// Reads only, watchdog must fire
		n = 0;
		while (sysResetN && n < 2 * `WDOG_LIMIT)
		begin
			driveCycle(0, 1, 0, (n % 10 == 0) ? 3 : 0);
			@(negedge CLK_1MB);
			n++;
		end
		if (sysResetN)
		begin
			$display("=== FAIL ===");
			$fatal(1, "watchdog never fired after kicks stopped");
		end
		// Last kick lands one edge late, leaving half the limit less two idle edges
		checkEq("watchdog idle cycles", `WDOG_LIMIT, n + `WDOG_LIMIT / 2 - 2);
		n = 0;
		while (!sysResetN && n < 4 * `WDOG_PULSE)
		begin
			driveCycle(0, 1, 0, 0);
			@(negedge CLK_1MB);
			n++;
		end
		checkEq("sysResetN pulse length", `WDOG_PULSE, n);

		if (errCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== include/pixel_defs.svh ====
`ifndef PIXEL_DEFS_SVH
`define PIXEL_DEFS_SVH

// Line buffer geometry
`define LB_DEPTH 256                   // Pixels per sprite line
`define LB_ADDR_W $clog2(`LB_DEPTH)    // X counter width

// Palette RAM address width
`define PAL_ADDR_W 12

// Watchdog timing, kept short for simulation
`define WDOG_LIMIT 64                  // Idle cycles before firing
`define WDOG_PULSE 8                   // Reset pulse length in cycles

// Decoded CPU target codes
`define REG_CODE_NONE     2'd0
`define REG_CODE_PALETTE  2'd1
`define REG_CODE_WATCHDOG 2'd2

`endif

// ==== tb.f ====
+incdir+include
design/pixelPkg.sv
design/spriteLineBuffers.sv
design/fixPipeline.sv
design/paletteMixer.sv
design/cpuWatchdog.sv
design/videoBackEnd.sv
dv/videoBackEnd_asserts.sv
dv/videoBackEnd_tb.sv
